// ==== warp_pkg.sv ====
`default_nettype none

package warp_pkg;

	// Core dimensions, fixed because the structs below depend on them
	localparam int NUM_WARPS   = 4;
	localparam int NUM_THREADS = 4;
	localparam int WARP_W      = 2;

	// Control operations reported by the execution stage
	typedef enum logic [3:0] {
		OP_NONE,
		OP_TMC,
		OP_SPLIT,
		OP_JOIN,
		OP_JUMP,
		OP_RESUME,
		OP_WSTALL,
		OP_BARRIER,
		OP_HALT
	} ctl_op_e;

	typedef struct packed {
		ctl_op_e                 op;
		logic [WARP_W-1:0]       warp;
		logic [31:0]             pc;          // Jump target or split save PC
		logic [NUM_THREADS-1:0]  mask;
		logic [NUM_THREADS-1:0]  later_mask;  // Else-mask of a split
		logic [1:0]              bar_id;
		logic [2:0]              bar_count;   // Warps expected at the barrier
	} warp_ctl_t;

	// Offer to the fetch stage
	typedef struct packed {
		logic                    valid;
		logic [WARP_W-1:0]       warp;
		logic [31:0]             pc;
		logic [NUM_THREADS-1:0]  mask;
	} issue_t;

	typedef struct packed {
		logic [NUM_WARPS-1:0] active;
		logic [NUM_WARPS-1:0] stalled;
		logic [NUM_WARPS-1:0] barrier_wait;
	} warp_status_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_HALTED
	} sched_state_e;

endpackage

`default_nettype wire

// ==== ipdom_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module ipdom_stack #(
	parameter int WIDTH = 37,
	parameter int DEPTH = 4
) (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             push,
	input  wire logic             pop,
	input  wire logic [WIDTH-1:0] entry_taken,
	input  wire logic [WIDTH-1:0] entry_later,
	output logic      [WIDTH-1:0] top_entry
);

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int PTR_W = IDX_W + 1;

	logic [WIDTH-1:0] entries [DEPTH];
	logic [PTR_W-1:0] ptr;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] top_idx;

	assign wr_idx  = ptr[IDX_W-1:0];
	// ptr counts entries, so the top sits one below it
	assign top_idx = IDX_W'(ptr - 1'b1);

	// Push stores the fall-through marker first, the later entry on top
	always_ff @(posedge clk) begin
		if (push) begin
			entries[wr_idx]                 <= entry_taken;
			entries[IDX_W'(wr_idx + 1'b1)]  <= entry_later;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + PTR_W'(2);
		end else if (pop && (ptr != '0)) begin
			ptr <= ptr - 1'b1;
		end
	end

	assign top_entry = entries[top_idx];

endmodule

`default_nettype wire

// ==== warp_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_table #(
	parameter int STACK_DEPTH  = 4,
	parameter int NUM_BARRIERS = 2
) (
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire warp_pkg::warp_ctl_t                ctl,
	input  wire logic                               spawn,
	input  wire logic [31:0]                        spawn_pc,
	input  wire logic [warp_pkg::NUM_WARPS-1:0]     spawn_mask,
	input  wire logic                               fire,
	input  wire logic [warp_pkg::WARP_W-1:0]        fire_warp,
	input  wire logic [warp_pkg::WARP_W-1:0]        sel_warp,
	output logic      [31:0]                        sel_pc,
	output logic      [warp_pkg::NUM_THREADS-1:0]   sel_mask,
	output warp_pkg::warp_status_t                  status
);

	localparam int NW    = warp_pkg::NUM_WARPS;
	localparam int NT    = warp_pkg::NUM_THREADS;
	localparam int BAR_W = (NUM_BARRIERS > 1) ? $clog2(NUM_BARRIERS) : 1;

	// Reconvergence entry kept on each warp's divergence stack
	typedef struct packed {
		logic          fall;
		logic [31:0]   pc;
		logic [NT-1:0] mask;
	} stack_entry_t;

	logic [31:0]   pcs   [NW];
	logic [NT-1:0] masks [NW];
	logic [NW-1:0] active;
	logic [NW-1:0] stalled;
	logic [NW-1:0] bar_mask [NUM_BARRIERS];
	logic [NW-1:0] bar_any;

	stack_entry_t  tops  [NW];
	stack_entry_t  entry_taken;
	stack_entry_t  entry_later;
	stack_entry_t  join_top;

	logic [BAR_W-1:0] bar_sel;
	logic             bar_release;

	assign entry_taken = '{fall: 1'b1, pc: 32'h0, mask: masks[ctl.warp]};
	assign entry_later = '{fall: 1'b0, pc: ctl.pc, mask: ctl.later_mask};
	assign join_top    = tops[ctl.warp];

	for (genvar w = 0; w < NW; w++) begin : g_stack
		ipdom_stack #(
			.WIDTH ($bits(stack_entry_t)),
			.DEPTH (STACK_DEPTH)
		) stack_i (
			.clk         (clk),
			.reset       (reset),
			.push        ((ctl.op == warp_pkg::OP_SPLIT) && (ctl.warp == w)),
			.pop         ((ctl.op == warp_pkg::OP_JOIN) && (ctl.warp == w)),
			.entry_taken (entry_taken),
			.entry_later (entry_later),
			.top_entry   (tops[w])
		);
	end

	// Last arrival releases the barrier
	assign bar_sel     = BAR_W'(ctl.bar_id);
	assign bar_release = ($countones(bar_mask[bar_sel]) + 1) == int'(ctl.bar_count);

	always_comb begin
		bar_any = '0;
		for (int b = 0; b < NUM_BARRIERS; b++) begin
			bar_any = bar_any | bar_mask[b];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active  <= '0;
			stalled <= '0;
			for (int w = 0; w < NW; w++) begin
				pcs[w]   <= '0;
				masks[w] <= '0;
			end
			for (int b = 0; b < NUM_BARRIERS; b++) begin
				bar_mask[b] <= '0;
			end
		end else begin
			if (fire) begin
				pcs[fire_warp] <= pcs[fire_warp] + 32'd4;
			end

			// Applied after the increment so an operation wins on the same warp
			case (ctl.op)
				warp_pkg::OP_TMC: begin
					masks[ctl.warp]   <= ctl.mask;
					stalled[ctl.warp] <= 1'b0;
				end
				warp_pkg::OP_SPLIT: masks[ctl.warp] <= ctl.mask;
				warp_pkg::OP_JOIN: begin
					masks[ctl.warp] <= join_top.mask;
					if (!join_top.fall) begin
						pcs[ctl.warp] <= join_top.pc;
					end
				end
				warp_pkg::OP_JUMP: begin
					pcs[ctl.warp]     <= ctl.pc;
					stalled[ctl.warp] <= 1'b0;
				end
				warp_pkg::OP_RESUME: stalled[ctl.warp] <= 1'b0;
				warp_pkg::OP_WSTALL: stalled[ctl.warp] <= 1'b1;
				warp_pkg::OP_BARRIER: begin
					if (bar_release) begin
						bar_mask[bar_sel] <= '0;
					end else begin
						bar_mask[bar_sel][ctl.warp] <= 1'b1;
					end
				end
				warp_pkg::OP_HALT: active[ctl.warp] <= 1'b0;
				default: ;
			endcase

			if (spawn) begin
				active  <= spawn_mask;
				stalled <= '0;
				for (int b = 0; b < NUM_BARRIERS; b++) begin
					bar_mask[b] <= '0;
				end
				for (int w = 0; w < NW; w++) begin
					if (spawn_mask[w]) begin
						pcs[w]   <= spawn_pc;
						masks[w] <= NT'(1);
					end
				end
			end
		end
	end

	assign sel_pc   = pcs[sel_warp];
	assign sel_mask = masks[sel_warp];

	assign status.active       = active;
	assign status.stalled      = stalled;
	assign status.barrier_wait = bar_any;

endmodule

`default_nettype wire

// ==== sched_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_fsm (
	input  wire logic                             clk,
	input  wire logic                             reset,
	input  wire logic                             start,
	input  wire logic                             stall,
	input  wire warp_pkg::warp_status_t           status,
	input  wire logic [31:0]                      sel_pc,
	input  wire logic [warp_pkg::NUM_THREADS-1:0] sel_mask,
	output logic                                  spawn,
	output logic      [warp_pkg::WARP_W-1:0]      sel_warp,
	output logic                                  fire,
	output logic      [warp_pkg::WARP_W-1:0]      fire_warp,
	output warp_pkg::issue_t                      issue,
	output warp_pkg::sched_state_e                state,
	output logic                                  count_en,
	output logic                                  ebreak
);

	warp_pkg::sched_state_e state_next;

	logic [warp_pkg::NUM_WARPS-1:0] round;
	logic [warp_pkg::NUM_WARPS-1:0] ready;
	logic [warp_pkg::NUM_WARPS-1:0] pool;
	logic [warp_pkg::WARP_W-1:0]    pick;
	logic                           refill;

	assign ready  = status.active & ~status.stalled & ~status.barrier_wait;
	// Round is exhausted, start a new one from every ready warp
	assign refill = (round & ready) == '0;
	assign pool   = refill ? ready : (round & ready);

	// Lowest index wins
	always_comb begin
		pick = '0;
		for (int i = warp_pkg::NUM_WARPS - 1; i >= 0; i--) begin
			if (pool[i]) begin
				pick = i[warp_pkg::WARP_W-1:0];
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			warp_pkg::ST_IDLE:   if (start) state_next = warp_pkg::ST_RUN;
			warp_pkg::ST_RUN:    if (status.active == '0) state_next = warp_pkg::ST_HALTED;
			warp_pkg::ST_HALTED: if (start) state_next = warp_pkg::ST_RUN;
			default:             state_next = warp_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= warp_pkg::ST_IDLE;
			round <= '0;
		end else begin
			state <= state_next;
			if (state != warp_pkg::ST_RUN) begin
				round <= '0;
			end else begin
				round <= pool;
				if (fire) begin
					round[pick] <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		issue.valid = (state == warp_pkg::ST_RUN) && (pool != '0) && (sel_mask != '0);
		issue.warp  = pick;
		issue.pc    = sel_pc;
		issue.mask  = sel_mask;
	end

	assign spawn     = start && (state != warp_pkg::ST_RUN);
	assign sel_warp  = pick;
	assign fire      = issue.valid && !stall;
	assign fire_warp = pick;
	assign count_en  = (state == warp_pkg::ST_RUN);
	assign ebreak    = (state == warp_pkg::ST_HALTED);

endmodule

`default_nettype wire

// ==== issue_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_counter (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        clear,
	input  wire logic        count_en,
	input  wire logic        fire,
	output logic      [31:0] issue_count,
	output logic      [31:0] cycle_count
);

	// Taken issues
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			issue_count <= '0;
		end else if (clear) begin
			issue_count <= '0;
		end else if (fire) begin
			issue_count <= issue_count + 32'd1;
		end
	end

	// Cycles spent running
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cycle_count <= '0;
		end else if (clear) begin
			cycle_count <= '0;
		end else if (count_en) begin
			cycle_count <= cycle_count + 32'd1;
		end
	end

endmodule

`default_nettype wire

// ==== sched_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_apb_regs (
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  wire logic [7:0]                     paddr,
	input  wire logic                           psel,
	input  wire logic                           penable,
	input  wire logic                           pwrite,
	input  wire logic [31:0]                    pwdata,
	output logic      [31:0]                    prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  wire warp_pkg::sched_state_e         state,
	input  wire logic [warp_pkg::NUM_WARPS-1:0] active,
	input  wire logic                           ebreak,
	input  wire logic [31:0]                    issue_count,
	input  wire logic [31:0]                    cycle_count,
	output logic                                start,
	output logic      [31:0]                    spawn_pc,
	output logic      [warp_pkg::NUM_WARPS-1:0] spawn_mask
);

	localparam logic [7:0] ADDR_CTRL        = 8'h00;
	localparam logic [7:0] ADDR_SPAWN_PC    = 8'h04;
	localparam logic [7:0] ADDR_SPAWN_MASK  = 8'h08;
	localparam logic [7:0] ADDR_STATUS      = 8'h0C;
	localparam logic [7:0] ADDR_ISSUE_COUNT = 8'h10;
	localparam logic [7:0] ADDR_CYCLE_COUNT = 8'h14;

	logic access;
	logic wr_en;
	logic known;

	assign access = psel && penable;
	assign wr_en  = access && pwrite;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			start      <= 1'b0;
			spawn_pc   <= '0;
			spawn_mask <= '0;
		end else begin
			// One-cycle pulse, seen by the FSM after the access edge
			start <= wr_en && (paddr == ADDR_CTRL) && pwdata[0];
			if (wr_en && (paddr == ADDR_SPAWN_PC)) begin
				spawn_pc <= pwdata;
			end
			if (wr_en && (paddr == ADDR_SPAWN_MASK)) begin
				spawn_mask <= pwdata[warp_pkg::NUM_WARPS-1:0];
			end
		end
	end

	always_comb begin
		known  = 1'b1;
		prdata = '0;
		case (paddr)
			ADDR_CTRL:        prdata = '0;
			ADDR_SPAWN_PC:    prdata = spawn_pc;
			ADDR_SPAWN_MASK:  prdata = 32'(spawn_mask);
			ADDR_STATUS:      prdata = 32'({ebreak, active, 2'b00, state});
			ADDR_ISSUE_COUNT: prdata = issue_count;
			ADDR_CYCLE_COUNT: prdata = cycle_count;
			default:          known  = 1'b0;
		endcase
	end

	// No wait states
	assign pready  = 1'b1;
	assign pslverr = access && !known;

endmodule

`default_nettype wire

// ==== warp_sched_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_sched_top #(
	parameter int STACK_DEPTH  = 4,
	parameter int NUM_BARRIERS = 2
) (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic [7:0]          paddr,
	input  wire logic                psel,
	input  wire logic                penable,
	input  wire logic                pwrite,
	input  wire logic [31:0]         pwdata,
	output logic      [31:0]         prdata,
	output logic                     pready,
	output logic                     pslverr,
	input  wire warp_pkg::warp_ctl_t ctl,
	input  wire logic                stall,
	output warp_pkg::issue_t         issue,
	output logic                     ebreak
);

	logic                             start;
	logic [31:0]                      spawn_pc;
	logic [warp_pkg::NUM_WARPS-1:0]   spawn_mask;
	logic                             spawn;
	logic                             fire;
	logic [warp_pkg::WARP_W-1:0]      fire_warp;
	logic [warp_pkg::WARP_W-1:0]      sel_warp;
	logic [31:0]                      sel_pc;
	logic [warp_pkg::NUM_THREADS-1:0] sel_mask;
	logic                             count_en;
	logic [31:0]                      issue_count;
	logic [31:0]                      cycle_count;
	warp_pkg::warp_status_t           status;
	warp_pkg::sched_state_e           state;

	sched_apb_regs regs_i (
		.clk         (clk),
		.reset       (reset),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.state       (state),
		.active      (status.active),
		.ebreak      (ebreak),
		.issue_count (issue_count),
		.cycle_count (cycle_count),
		.start       (start),
		.spawn_pc    (spawn_pc),
		.spawn_mask  (spawn_mask)
	);

	warp_table #(
		.STACK_DEPTH  (STACK_DEPTH),
		.NUM_BARRIERS (NUM_BARRIERS)
	) table_i (
		.clk        (clk),
		.reset      (reset),
		.ctl        (ctl),
		.spawn      (spawn),
		.spawn_pc   (spawn_pc),
		.spawn_mask (spawn_mask),
		.fire       (fire),
		.fire_warp  (fire_warp),
		.sel_warp   (sel_warp),
		.sel_pc     (sel_pc),
		.sel_mask   (sel_mask),
		.status     (status)
	);

	sched_fsm fsm_i (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.stall     (stall),
		.status    (status),
		.sel_pc    (sel_pc),
		.sel_mask  (sel_mask),
		.spawn     (spawn),
		.sel_warp  (sel_warp),
		.fire      (fire),
		.fire_warp (fire_warp),
		.issue     (issue),
		.state     (state),
		.count_en  (count_en),
		.ebreak    (ebreak)
	);

	issue_counter counter_i (
		.clk         (clk),
		.reset       (reset),
		.clear       (start),
		.count_en    (count_en),
		.fire        (fire),
		.issue_count (issue_count),
		.cycle_count (cycle_count)
	);

endmodule

`default_nettype wire

// ==== warp_sched_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_sched_checker (
	input wire logic                   clk,
	input wire logic                   reset,
	input wire logic                   pready,
	input wire logic                   stall,
	input wire warp_pkg::warp_ctl_t    ctl,
	input wire warp_pkg::issue_t       issue,
	input wire warp_pkg::sched_state_e state
);

	// Failed assertions, read by the testbench at the end
	int fail_count = 0;

	valid_mask_a: assert property (@(posedge clk) disable iff (reset)
		issue.valid |-> (issue.mask != '0))
	else begin
		$error("issue offered with an empty thread mask");
		fail_count++;
	end

	// Offers only while running
	run_only_a: assert property (@(posedge clk) disable iff (reset)
		(state != warp_pkg::ST_RUN) |-> !issue.valid)
	else begin
		$error("issue offered outside the run state");
		fail_count++;
	end

	pready_a: assert property (@(posedge clk) disable iff (reset) pready)
	else begin
		$error("pready dropped");
		fail_count++;
	end

	// Held offer must not move unless a control operation touched the table
	stable_a: assert property (@(posedge clk) disable iff (reset)
		(issue.valid && stall && (ctl.op == warp_pkg::OP_NONE)) |=> $stable(issue))
	else begin
		$error("issue changed while stalled");
		fail_count++;
	end

endmodule

bind warp_sched_top warp_sched_checker chk_i (
	.clk    (clk),
	.reset  (reset),
	.pready (pready),
	.stall  (stall),
	.ctl    (ctl),
	.issue  (issue),
	.state  (state)
);

`default_nettype wire

// ==== warp_sched_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_sched_tb;

	localparam int TIMEOUT = 64;

	localparam logic [7:0] A_CTRL       = 8'h00;
	localparam logic [7:0] A_SPAWN_PC   = 8'h04;
	localparam logic [7:0] A_SPAWN_MASK = 8'h08;
	localparam logic [7:0] A_STATUS     = 8'h0C;
	localparam logic [7:0] A_ISSUE      = 8'h10;
	localparam logic [7:0] A_CYCLE      = 8'h14;

	// Spawn PC, jump target and split save PC
	localparam logic [31:0] P = 32'h0000_1000;
	localparam logic [31:0] J = 32'h0000_2000;
	localparam logic [31:0] S = 32'h0000_3000;

	typedef enum logic [3:0] {
		K_WRITE, K_READ, K_SNAP, K_SAME, K_BAD_ADDR, K_CTL, K_ISSUE, K_IDLE, K_EBREAK
	} kind_e;

	typedef struct packed {
		logic [2:0]          test;
		kind_e               kind;
		logic [7:0]          addr;       // For idle rows bit 0 is the expected ebreak
		logic [31:0]         data;       // Write data, read value or idle cycles
		warp_pkg::warp_ctl_t ctl;
		warp_pkg::issue_t    exp;
		logic                rand_stall;
	} row_t;

	logic                clk;
	logic                reset;
	logic [7:0]          paddr;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [31:0]         pwdata;
	logic [31:0]         prdata;
	logic                pready;
	logic                pslverr;
	warp_pkg::warp_ctl_t ctl;
	logic                stall;
	warp_pkg::issue_t    issue;
	logic                ebreak;

	row_t        rows[$];
	logic [31:0] lfsr;
	logic [31:0] last_read;
	int          errors;
	int          checks;

	warp_sched_top #(
		.STACK_DEPTH  (4),
		.NUM_BARRIERS (2)
	) dut_i (
		.clk     (clk),
		.reset   (reset),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.ctl     (ctl),
		.stall   (stall),
		.issue   (issue),
		.ebreak  (ebreak)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2;
			clk = ~clk;
		end
	end

	initial begin
		#50000;
		$display("Simulation ran past its time limit");
		$display("Test failed");
		$finish;
	end

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic row_t make_apb(input int t, input kind_e k, input logic [7:0] a,
			input logic [31:0] d);
		row_t r;
		r = '0;
		r.test = 3'(t);
		r.kind = k;
		r.addr = a;
		r.data = d;
		return r;
	endfunction

	function automatic row_t make_ctl(input int t, input warp_pkg::ctl_op_e op, input int w,
			input logic [31:0] pc, input logic [3:0] m, input logic [3:0] lm, input int cnt);
		row_t r;
		r = '0;
		r.test = 3'(t);
		r.kind = K_CTL;
		r.ctl.op = op;
		r.ctl.warp = 2'(w);
		r.ctl.pc = pc;
		r.ctl.mask = m;
		r.ctl.later_mask = lm;
		r.ctl.bar_count = 3'(cnt);
		return r;
	endfunction

	function automatic row_t make_issue(input int t, input int w, input logic [31:0] pc,
			input logic [3:0] m, input logic rs);
		row_t r;
		r = '0;
		r.test = 3'(t);
		r.kind = K_ISSUE;
		r.exp.valid = 1'b1;
		r.exp.warp = 2'(w);
		r.exp.pc = pc;
		r.exp.mask = m;
		r.rand_stall = rs;
		return r;
	endfunction

	// Expected order follows the round rules: lowest ready index first,
	// refill from all ready warps once the round runs dry
	task automatic build_table();
		rows.push_back(make_apb(1, K_READ, A_STATUS, 32'h0));
		rows.push_back(make_apb(1, K_READ, A_ISSUE, 32'h0));
		rows.push_back(make_apb(1, K_READ, A_CYCLE, 32'h0));
		rows.push_back(make_apb(1, K_IDLE, 8'h00, 32'd5));
		rows.push_back(make_apb(1, K_WRITE, A_SPAWN_PC, P));
		rows.push_back(make_apb(1, K_WRITE, A_SPAWN_MASK, 32'hB));
		rows.push_back(make_apb(1, K_READ, A_SPAWN_PC, P));
		rows.push_back(make_apb(1, K_READ, A_SPAWN_MASK, 32'hB));
		rows.push_back(make_apb(1, K_BAD_ADDR, 8'h20, 32'h0));
		rows.push_back(make_apb(2, K_WRITE, A_CTRL, 32'h1));
		rows.push_back(make_issue(2, 0, P, 4'b0001, 1'b1));
		rows.push_back(make_issue(2, 1, P, 4'b0001, 1'b1));
		rows.push_back(make_issue(2, 3, P, 4'b0001, 1'b1));
		rows.push_back(make_issue(2, 0, P + 4, 4'b0001, 1'b1));
		rows.push_back(make_issue(2, 1, P + 4, 4'b0001, 1'b1));
		rows.push_back(make_issue(2, 3, P + 4, 4'b0001, 1'b1));
		rows.push_back(make_apb(2, K_READ, A_ISSUE, 32'd6));
		rows.push_back(make_ctl(3, warp_pkg::OP_JUMP, 1, J, 4'h0, 4'h0, 0));
		rows.push_back(make_ctl(3, warp_pkg::OP_TMC, 3, 32'h0, 4'b0110, 4'h0, 0));
		rows.push_back(make_issue(3, 0, P + 8, 4'b0001, 1'b0));
		rows.push_back(make_issue(3, 1, J, 4'b0001, 1'b0));
		rows.push_back(make_issue(3, 3, P + 8, 4'b0110, 1'b0));
		// Split on warp 0, then two joins
		rows.push_back(make_ctl(4, warp_pkg::OP_SPLIT, 0, S, 4'b0010, 4'b1100, 0));
		rows.push_back(make_issue(4, 0, P + 12, 4'b0010, 1'b1));
		rows.push_back(make_ctl(4, warp_pkg::OP_JOIN, 0, 32'h0, 4'h0, 4'h0, 0));
		rows.push_back(make_issue(4, 1, J + 4, 4'b0001, 1'b1));
		rows.push_back(make_issue(4, 3, P + 12, 4'b0110, 1'b1));
		rows.push_back(make_issue(4, 0, S, 4'b1100, 1'b1));
		rows.push_back(make_ctl(4, warp_pkg::OP_JOIN, 0, 32'h0, 4'h0, 4'h0, 0));
		rows.push_back(make_issue(4, 1, J + 8, 4'b0001, 1'b1));
		rows.push_back(make_issue(4, 3, P + 16, 4'b0110, 1'b1));
		rows.push_back(make_issue(4, 0, S + 4, 4'b0001, 1'b1));
		// Warp 1 stalled, warp 3 parked at barrier 0 until warp 0 arrives
		rows.push_back(make_ctl(5, warp_pkg::OP_WSTALL, 1, 32'h0, 4'h0, 4'h0, 0));
		rows.push_back(make_ctl(5, warp_pkg::OP_BARRIER, 3, 32'h0, 4'h0, 4'h0, 2));
		rows.push_back(make_issue(5, 0, S + 8, 4'b0001, 1'b1));
		rows.push_back(make_ctl(5, warp_pkg::OP_BARRIER, 0, 32'h0, 4'h0, 4'h0, 2));
		rows.push_back(make_issue(5, 0, S + 12, 4'b0001, 1'b1));
		rows.push_back(make_issue(5, 0, S + 16, 4'b0001, 1'b1));
		rows.push_back(make_issue(5, 3, P + 20, 4'b0110, 1'b1));
		rows.push_back(make_ctl(5, warp_pkg::OP_RESUME, 1, 32'h0, 4'h0, 4'h0, 0));
		rows.push_back(make_issue(5, 0, S + 20, 4'b0001, 1'b1));
		rows.push_back(make_issue(5, 3, P + 24, 4'b0110, 1'b1));
		rows.push_back(make_issue(5, 0, S + 24, 4'b0001, 1'b1));
		rows.push_back(make_issue(5, 1, J + 12, 4'b0001, 1'b1));
		for (int w = 0; w < warp_pkg::NUM_WARPS; w++) begin
			rows.push_back(make_ctl(6, warp_pkg::OP_HALT, w, 32'h0, 4'h0, 4'h0, 0));
		end
		rows.push_back(make_apb(6, K_EBREAK, 8'h00, 32'h0));
		rows.push_back(make_apb(6, K_IDLE, 8'h01, 32'd5));
		rows.push_back(make_apb(6, K_READ, A_STATUS, 32'h102));
		rows.push_back(make_apb(6, K_READ, A_ISSUE, 32'd24));
		rows.push_back(make_apb(6, K_SNAP, A_CYCLE, 32'h0));
		rows.push_back(make_apb(6, K_IDLE, 8'h01, 32'd8));
		rows.push_back(make_apb(6, K_SAME, A_CYCLE, 32'h0));
	endtask

	// Access phase lasts until pready
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!pready && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!pready) begin
			errors++;
			$display("APB slave never raised pready during the access phase");
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		@(posedge clk);
		#1;
		penable = 1'b1;
		wait_ready();
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
			output logic err);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		@(posedge clk);
		#1;
		penable = 1'b1;
		wait_ready();
		data = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// Waits for one taken issue and compares its fields
	task automatic take_issue(input warp_pkg::issue_t exp, input logic rs);
		int   n;
		logic taken;
		n = 0;
		taken = 1'b0;
		while (!taken && n < TIMEOUT) begin
			if (rs) begin
				lfsr = lfsr_next(lfsr);
				stall = lfsr[0];
			end else begin
				stall = 1'b0;
			end
			@(negedge clk);
			if (issue.valid && !stall) begin
				taken = 1'b1;
				check_value("issue.warp", 32'(issue.warp), 32'(exp.warp));
				check_value("issue.pc", issue.pc, exp.pc);
				check_value("issue.mask", 32'(issue.mask), 32'(exp.mask));
			end
			@(posedge clk);
			#1;
			n++;
		end
		stall = 1'b1;
		if (!taken) begin
			errors++;
			$display("Timed out at %0d ns waiting for warp %0d to issue", $time, exp.warp);
		end
	endtask

	task automatic idle_cycles(input logic [31:0] n, input logic exp_ebreak);
		stall = 1'b0;
		repeat (n) begin
			@(negedge clk);
			check_value("issue.valid", 32'(issue.valid), 32'h0);
			check_value("ebreak", 32'(ebreak), 32'(exp_ebreak));
			@(posedge clk);
			#1;
		end
		stall = 1'b1;
	endtask

	task automatic wait_ebreak();
		int n;
		n = 0;
		while (!ebreak && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!ebreak) begin
			errors++;
			$display("Timed out waiting for ebreak after halting every warp");
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] rd;
		logic        err;
		case (r.kind)
			K_WRITE: apb_write(r.addr, r.data);
			K_READ, K_SNAP, K_SAME, K_BAD_ADDR: begin
				apb_read(r.addr, rd, err);
				check_value("pslverr", 32'(err), 32'(r.kind == K_BAD_ADDR));
				if (r.kind == K_READ) begin
					check_value($sformatf("prdata[%h]", r.addr), rd, r.data);
				end
				if (r.kind == K_SAME) begin
					check_value($sformatf("prdata[%h]", r.addr), rd, last_read);
				end
				last_read = rd;
			end
			K_CTL: begin
				ctl = r.ctl;
				@(posedge clk);
				#1;
				ctl = '0;
			end
			K_ISSUE:  take_issue(r.exp, r.rand_stall);
			K_IDLE:   idle_cycles(r.data, r.addr[0]);
			K_EBREAK: wait_ebreak();
			default: ;
		endcase
	endtask

	task automatic report_behavior(input int t, input int errs);
		$display("Behavior %0d finished with %0d errors", t, errs);
	endtask

	initial begin
		int cur_test;
		int errors_before;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		ctl = '0;
		stall = 1'b1;
		lfsr = 32'hcb42;
		last_read = '0;
		errors = 0;
		checks = 0;
		build_table();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		cur_test = int'(rows[0].test);
		errors_before = 0;
		foreach (rows[i]) begin
			if (int'(rows[i].test) != cur_test) begin
				report_behavior(cur_test, errors - errors_before);
				cur_test = int'(rows[i].test);
				errors_before = errors;
			end
			apply_row(rows[i]);
		end
		report_behavior(cur_test, errors - errors_before);
		errors = errors + dut_i.chk_i.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			dut_i.chk_i.fail_count);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
warp_pkg.sv
ipdom_stack.sv
warp_table.sv
sched_fsm.sv
issue_counter.sv
sched_apb_regs.sv
warp_sched_top.sv
warp_sched_checker.sv
warp_sched_tb.sv

// ==== Bender.yml ====
package:
  name: warp_sched

sources:
  - warp_pkg.sv
  - ipdom_stack.sv
  - warp_table.sv
  - sched_fsm.sv
  - issue_counter.sv
  - sched_apb_regs.sv
  - warp_sched_top.sv
  - target: test
    files:
      - warp_sched_checker.sv
      - warp_sched_tb.sv
